//--- design/mipsPkg.sv
// MIPS core shared definitions
package mipsPkg;

    localparam int wordWidth = 32;  // Data and address width
    localparam int regCount = 32;   // General registers

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [$clog2(regCount)-1:0] regIndex_t;

    localparam word_t resetVector = 32'hBFC00000;  // First fetch
    localparam word_t haltAddress = 32'h00000000;  // PC that stops the core
    localparam regIndex_t resultReg = 5'd2;        // $v0

    // Primary opcodes kept by this core
    typedef enum logic [5:0] {
        OPCODE_RTYPE = 6'd0,
        OPCODE_J     = 6'd2,
        OPCODE_BEQ   = 6'd4,
        OPCODE_BNE   = 6'd5,
        OPCODE_ADDIU = 6'd9,
        OPCODE_SLTI  = 6'd10,
        OPCODE_SLTIU = 6'd11,
        OPCODE_ANDI  = 6'd12,
        OPCODE_ORI   = 6'd13,
        OPCODE_XORI  = 6'd14,
        OPCODE_LUI   = 6'd15,
        OPCODE_LW    = 6'd35,
        OPCODE_SW    = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'd0,
        FUNCT_SRL  = 6'd2,
        FUNCT_SRA  = 6'd3,
        FUNCT_JR   = 6'd8,
        FUNCT_ADDU = 6'd33,
        FUNCT_SUBU = 6'd35,
        FUNCT_AND  = 6'd36,
        FUNCT_OR   = 6'd37,
        FUNCT_XOR  = 6'd38,
        FUNCT_SLT  = 6'd42,
        FUNCT_SLTU = 6'd43
    } funct_t;

    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        EXEC   = 2'd1,
        MEMORY = 2'd2,
        HALT   = 2'd3
    } cpuState_t;

    // Three views of one instruction word
    typedef union packed {
        struct packed {
            opcode_t opcode;
            regIndex_t rs;
            regIndex_t rt;
            regIndex_t rd;
            logic [4:0] shamt;
            funct_t funct;
        } rFormat;
        struct packed {
            opcode_t opcode;
            regIndex_t rs;
            regIndex_t rt;
            logic [15:0] immediate;
        } iFormat;
        struct packed {
            opcode_t opcode;
            logic [25:0] target;
        } jFormat;
    } instruction_t;

endpackage

//--- design/busMaster.sv
// Avalon memory-mapped master
`timescale 1ns/1ps

module busMaster (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               fetchReq,
    input  logic                               dataRead,
    input  logic                               dataWrite,
    input  mipsPkg::word_t                     pc,
    input  mipsPkg::word_t                     memAddress,
    input  mipsPkg::word_t                     storeData,
    output logic                               accessDone,
    output mipsPkg::word_t                     loadData,
    output mipsPkg::word_t                     address,
    output logic                               read,
    output logic                               write,
    output mipsPkg::word_t                     writedata,
    output logic [mipsPkg::wordWidth/8-1:0]    byteenable,
    input  logic                               waitrequest,
    input  mipsPkg::word_t                     readdata
);
    logic stalled;                // Previous cycle was a stall
    mipsPkg::word_t reqAddress;
    mipsPkg::word_t heldAddress;  // Frozen while stalled
    mipsPkg::word_t heldData;

    assign reqAddress = fetchReq ? pc : memAddress;
    assign read = fetchReq | dataRead;
    assign write = dataWrite;
    assign address = stalled ? heldAddress : reqAddress;
    assign writedata = stalled ? heldData : storeData;
    assign byteenable = '1;  // Word accesses only
    assign accessDone = (read | write) & ~waitrequest;
    assign loadData = readdata;  // Valid in the completion cycle

    always_ff @(posedge clk) begin
        if (reset) stalled <= 1'b0;
        else stalled <= (read | write) & waitrequest;
    end

    // Capture on the first stalled cycle
    always_ff @(posedge clk) begin
        if (!stalled) begin
            heldAddress <= reqAddress;
            heldData <= storeData;
        end
    end

endmodule

//--- design/cpuControl.sv
// Multicycle control and program counter
`timescale 1ns/1ps

module cpuControl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     accessDone,
    input  mipsPkg::word_t           loadData,
    output logic                     fetchReq,
    output logic                     dataRead,
    output logic                     dataWrite,
    output logic                     active,
    output mipsPkg::word_t           pc,
    output mipsPkg::instruction_t    instr,
    output mipsPkg::regIndex_t       readIndexA,
    output mipsPkg::regIndex_t       readIndexB,
    input  mipsPkg::word_t           result,
    input  mipsPkg::word_t           jumpTarget,
    input  logic                     branchTaken,
    output logic                     writeEnable,
    output mipsPkg::regIndex_t       writeIndex,
    output mipsPkg::word_t           writeData
);
    mipsPkg::cpuState_t state;
    mipsPkg::word_t pendingTarget;  // Target waiting for the delay slot
    logic pendingValid;
    mipsPkg::word_t nextPc;
    logic haltNext;
    logic isRType;
    logic isLoad;
    logic isStore;
    logic writesReg;

    assign isRType = instr.rFormat.opcode == mipsPkg::OPCODE_RTYPE;
    assign isLoad = instr.iFormat.opcode == mipsPkg::OPCODE_LW;
    assign isStore = instr.iFormat.opcode == mipsPkg::OPCODE_SW;

    // Which instructions produce a register result in EXEC
    always_comb begin
        case (instr.iFormat.opcode)
            mipsPkg::OPCODE_RTYPE: writesReg = instr.rFormat.funct != mipsPkg::FUNCT_JR;
            mipsPkg::OPCODE_ADDIU, mipsPkg::OPCODE_SLTI, mipsPkg::OPCODE_SLTIU,
            mipsPkg::OPCODE_ANDI, mipsPkg::OPCODE_ORI, mipsPkg::OPCODE_XORI,
            mipsPkg::OPCODE_LUI: writesReg = 1'b1;
            default: writesReg = 1'b0;  // Branches, jumps, memory
        endcase
    end

    assign nextPc = pendingValid ? pendingTarget : pc + 32'd4;  // Delay slot done, take target
    assign haltNext = nextPc == mipsPkg::haltAddress;

    assign readIndexA = instr.rFormat.rs;
    assign readIndexB = instr.rFormat.rt;
    assign writeIndex = isRType ? instr.rFormat.rd : instr.iFormat.rt;
    assign writeData = (state == mipsPkg::MEMORY) ? loadData : result;
    assign writeEnable = ((state == mipsPkg::EXEC) && writesReg) ||
                         ((state == mipsPkg::MEMORY) && isLoad && accessDone);
    assign active = state != mipsPkg::HALT;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::FETCH;
            pc <= mipsPkg::resetVector;
            pendingValid <= 1'b0;
            fetchReq <= 1'b0;  // Raised one cycle after reset
            dataRead <= 1'b0;
            dataWrite <= 1'b0;
        end else begin
            case (state)
                mipsPkg::FETCH: begin
                    if (accessDone) begin
                        fetchReq <= 1'b0;
                        state <= mipsPkg::EXEC;
                    end else begin
                        fetchReq <= 1'b1;
                    end
                end
                mipsPkg::EXEC: begin
                    if (isLoad || isStore) begin
                        dataRead <= isLoad;
                        dataWrite <= isStore;
                        state <= mipsPkg::MEMORY;
                    end else begin
                        pc <= nextPc;
                        pendingValid <= branchTaken;  // Delay slot comes next
                        state <= haltNext ? mipsPkg::HALT : mipsPkg::FETCH;
                        fetchReq <= !haltNext;
                    end
                end
                mipsPkg::MEMORY: begin
                    if (accessDone) begin
                        dataRead <= 1'b0;
                        dataWrite <= 1'b0;
                        pc <= nextPc;
                        pendingValid <= 1'b0;
                        state <= haltNext ? mipsPkg::HALT : mipsPkg::FETCH;
                        fetchReq <= !haltNext;
                    end
                end
                default: state <= mipsPkg::HALT;  // Stays halted
            endcase
        end
    end

    // Instruction register and branch target
    always_ff @(posedge clk) begin
        if ((state == mipsPkg::FETCH) && accessDone) instr <= loadData;
        if ((state == mipsPkg::EXEC) && branchTaken) pendingTarget <= jumpTarget;
    end

endmodule

//--- design/aluUnit.sv
// Combinational execute unit
`timescale 1ns/1ps

module aluUnit (
    input  mipsPkg::instruction_t    instr,
    input  mipsPkg::word_t           operandA,
    input  mipsPkg::word_t           operandB,
    input  mipsPkg::word_t           pc,
    output mipsPkg::word_t           result,
    output mipsPkg::word_t           memAddress,
    output mipsPkg::word_t           jumpTarget,
    output logic                     branchTaken
);
    mipsPkg::word_t signExt;       // Arithmetic, compare, address
    mipsPkg::word_t zeroExt;       // Logic immediates
    mipsPkg::word_t pcPlus4;
    mipsPkg::word_t branchTarget;
    mipsPkg::word_t jTarget;

    assign signExt = {{16{instr.iFormat.immediate[15]}}, instr.iFormat.immediate};
    assign zeroExt = {16'b0, instr.iFormat.immediate};
    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signExt[29:0], 2'b00};  // Word offset from slot
    assign jTarget = {pcPlus4[31:28], instr.jFormat.target, 2'b00};
    assign memAddress = operandA + signExt;

    always_comb begin
        case (instr.rFormat.opcode)
            mipsPkg::OPCODE_RTYPE: begin
                case (instr.rFormat.funct)
                    mipsPkg::FUNCT_ADDU: result = operandA + operandB;
                    mipsPkg::FUNCT_SUBU: result = operandA - operandB;
                    mipsPkg::FUNCT_AND:  result = operandA & operandB;
                    mipsPkg::FUNCT_OR:   result = operandA | operandB;
                    mipsPkg::FUNCT_XOR:  result = operandA ^ operandB;
                    mipsPkg::FUNCT_SLT:  result = {31'b0, $signed(operandA) < $signed(operandB)};
                    mipsPkg::FUNCT_SLTU: result = {31'b0, operandA < operandB};
                    mipsPkg::FUNCT_SLL:  result = operandB << instr.rFormat.shamt;
                    mipsPkg::FUNCT_SRL:  result = operandB >> instr.rFormat.shamt;
                    mipsPkg::FUNCT_SRA:  result = $signed(operandB) >>> instr.rFormat.shamt;
                    default:             result = '0;  // JR and unsupported
                endcase
            end
            mipsPkg::OPCODE_ADDIU: result = operandA + signExt;
            mipsPkg::OPCODE_SLTI:  result = {31'b0, $signed(operandA) < $signed(signExt)};
            mipsPkg::OPCODE_SLTIU: result = {31'b0, operandA < signExt};  // Unsigned after extend
            mipsPkg::OPCODE_ANDI:  result = operandA & zeroExt;
            mipsPkg::OPCODE_ORI:   result = operandA | zeroExt;
            mipsPkg::OPCODE_XORI:  result = operandA ^ zeroExt;
            mipsPkg::OPCODE_LUI:   result = {instr.iFormat.immediate, 16'b0};
            default:               result = '0;
        endcase
    end

    // Branch decision and target
    always_comb begin
        case (instr.rFormat.opcode)
            mipsPkg::OPCODE_BEQ: begin
                branchTaken = operandA == operandB;
                jumpTarget = branchTarget;
            end
            mipsPkg::OPCODE_BNE: begin
                branchTaken = operandA != operandB;
                jumpTarget = branchTarget;
            end
            mipsPkg::OPCODE_J: begin
                branchTaken = 1'b1;
                jumpTarget = jTarget;
            end
            mipsPkg::OPCODE_RTYPE: begin
                branchTaken = instr.rFormat.funct == mipsPkg::FUNCT_JR;
                jumpTarget = operandA;  // JR goes to rs
            end
            default: begin
                branchTaken = 1'b0;
                jumpTarget = branchTarget;
            end
        endcase
    end

endmodule

//--- design/registerFile.sv
// General register file
`timescale 1ns/1ps

module registerFile (
    input  logic                  clk,
    input  logic                  reset,
    input  mipsPkg::regIndex_t    readIndexA,
    input  mipsPkg::regIndex_t    readIndexB,
    output mipsPkg::word_t        operandA,
    output mipsPkg::word_t        operandB,
    input  logic                  writeEnable,
    input  mipsPkg::regIndex_t    writeIndex,
    input  mipsPkg::word_t        writeData,
    output mipsPkg::word_t        register_v0
);
    mipsPkg::word_t regs [mipsPkg::regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mipsPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIndex != '0)) begin  // $zero stays zero
            regs[writeIndex] <= writeData;
        end
    end

    // Asynchronous reads
    assign operandA = regs[readIndexA];
    assign operandB = regs[readIndexB];
    assign register_v0 = regs[mipsPkg::resultReg];  // Result tap

endmodule

//--- design/mipsCpuBus.sv
// MIPS core with Avalon master
`timescale 1ns/1ps

module mipsCpuBus (
    input  logic                               clk,
    input  logic                               reset,
    output logic                               active,
    output mipsPkg::word_t                     register_v0,
    output mipsPkg::word_t                     address,
    output logic                               read,
    output logic                               write,
    output mipsPkg::word_t                     writedata,
    output logic [mipsPkg::wordWidth/8-1:0]    byteenable,
    input  logic                               waitrequest,
    input  mipsPkg::word_t                     readdata
);
    // Control to bus master
    logic fetchReq;
    logic dataRead;
    logic dataWrite;
    logic accessDone;
    mipsPkg::word_t loadData;
    mipsPkg::word_t pc;

    // Decode and execute
    mipsPkg::instruction_t instr;  // Current instruction register
    mipsPkg::regIndex_t readIndexA;
    mipsPkg::regIndex_t readIndexB;
    mipsPkg::word_t operandA;      // rs value
    mipsPkg::word_t operandB;      // rt value, also store data
    mipsPkg::word_t result;
    mipsPkg::word_t jumpTarget;
    mipsPkg::word_t memAddress;
    logic branchTaken;

    // Write-back port
    logic writeEnable;
    mipsPkg::regIndex_t writeIndex;
    mipsPkg::word_t writeData;

    busMaster busMaster_i (
        .clk(clk), .reset(reset),
        .fetchReq(fetchReq), .dataRead(dataRead), .dataWrite(dataWrite),
        .pc(pc), .memAddress(memAddress), .storeData(operandB),
        .accessDone(accessDone), .loadData(loadData),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

    cpuControl cpuControl_i (
        .clk(clk), .reset(reset),
        .accessDone(accessDone), .loadData(loadData),
        .fetchReq(fetchReq), .dataRead(dataRead), .dataWrite(dataWrite),
        .active(active), .pc(pc), .instr(instr),
        .readIndexA(readIndexA), .readIndexB(readIndexB),
        .result(result), .jumpTarget(jumpTarget), .branchTaken(branchTaken),
        .writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData)
    );

    aluUnit aluUnit_i (
        .instr(instr), .operandA(operandA), .operandB(operandB), .pc(pc),
        .result(result), .memAddress(memAddress), .jumpTarget(jumpTarget),
        .branchTaken(branchTaken)
    );

    registerFile registerFile_i (
        .clk(clk), .reset(reset),
        .readIndexA(readIndexA), .readIndexB(readIndexB),
        .operandA(operandA), .operandB(operandB),
        .writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData),
        .register_v0(register_v0)
    );

endmodule

//--- sim/avalonMemory.sv
// Avalon word memory model
`timescale 1ns/1ps

module avalonMemory (
    input  logic              clk,
    input  logic              reset,
    input  mipsPkg::word_t    address,
    input  logic              read,
    input  logic              write,
    input  mipsPkg::word_t    writedata,
    output logic              waitrequest,
    output mipsPkg::word_t    readdata,
    input  logic              loadEnable,   // Preload port from the testbench
    input  logic [5:0]        loadIndex,
    input  mipsPkg::word_t    loadData,
    input  logic [5:0]        peekIndex,    // Result inspection
    output mipsPkg::word_t    peekData
);
    mipsPkg::word_t mem [64];  // Word index is address[7:2]
    logic [7:0] lfsr;
    logic stall;               // Stall bit for the current cycle
    logic [5:0] index;

    // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrStep(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    assign index = address[7:2];
    assign waitrequest = (read | write) & stall;
    assign readdata = mem[index];  // Valid whenever waitrequest is low
    assign peekData = mem[peekIndex];

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 8'd18;  // Seed
            stall <= 1'b0;
        end else begin
            lfsr <= lfsrStep(lfsr);  // One step per bit taken
            stall <= lfsr[0];
        end
    end

    // Preload wins over bus writes
    always_ff @(posedge clk) begin
        if (loadEnable) begin
            mem[loadIndex] <= loadData;
        end else if (write && !waitrequest) begin
            mem[index] <= writedata;
        end
    end

endmodule

//--- sim/mipsCpuBusTb.sv
// MIPS core testbench
`timescale 1ns/1ps

module mipsCpuBusTb;
    logic clk;
    logic reset;
    logic active;
    mipsPkg::word_t register_v0;
    mipsPkg::word_t address;
    logic read;
    logic write;
    mipsPkg::word_t writedata;
    logic [3:0] byteenable;
    logic waitrequest;
    mipsPkg::word_t readdata;
    logic loadEnable;
    logic [5:0] loadIndex;
    mipsPkg::word_t loadData;
    logic [5:0] peekIndex;
    mipsPkg::word_t peekData;
    int holdErrors;                        // Requests that changed while stalled

    // Test table with one row per program
    string testName [5];
    mipsPkg::word_t programWords [5][20];  // Placed at resetVector
    int programLength [5];
    mipsPkg::word_t dataWord [5];          // Preloaded at dataAddress
    mipsPkg::word_t expectV0 [5];
    mipsPkg::word_t expectMem [5];         // Word at dataAddress after halt
    mipsPkg::word_t dataAddress;

    assign peekIndex = dataAddress[7:2];

    mipsCpuBus mipsCpuBus_i (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

    avalonMemory avalonMemory_i (
        .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata),
        .loadEnable(loadEnable), .loadIndex(loadIndex), .loadData(loadData),
        .peekIndex(peekIndex), .peekData(peekData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Avalon request stays steady through waitrequest
    initial begin
        logic prevStalled;
        logic prevRead;
        logic prevWrite;
        mipsPkg::word_t prevAddress;
        mipsPkg::word_t prevWritedata;
        holdErrors = 0;
        prevStalled = 1'b0;
        forever begin
            @(negedge clk);
            if (prevStalled && ((read !== prevRead) || (write !== prevWrite)
                    || (address !== prevAddress) || (writedata !== prevWritedata))) begin
                holdErrors++;
            end
            prevStalled = !reset && (read || write) && waitrequest;
            prevRead = read;
            prevWrite = write;
            prevAddress = address;
            prevWritedata = writedata;
        end
    end

    // Instruction encoders in MIPS-I field layout
    function automatic mipsPkg::word_t encodeR(input int rs, input int rt, input int rd,
                                               input int shamt, input mipsPkg::funct_t funct);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic mipsPkg::word_t encodeI(input mipsPkg::opcode_t op, input int rs,
                                               input int rt, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // Offset in words from the delay slot
    function automatic mipsPkg::word_t encodeBranch(input mipsPkg::opcode_t op, input int rs,
                                                    input int rt, input int fromWord,
                                                    input int toWord);
        return encodeI(op, rs, rt, toWord - fromWord - 1);
    endfunction

    function automatic mipsPkg::word_t encodeJump(input int toWord);
        mipsPkg::word_t target;
        target = mipsPkg::resetVector + 32'(toWord * 4);
        return {mipsPkg::OPCODE_J, target[27:2]};
    endfunction

    // Undefined opcode 0x3F with the byte address in the low bits
    function automatic mipsPkg::word_t fillWord(input int index);
        return {6'h3F, 18'd0, 6'(index), 2'b00};
    endfunction

    task automatic setTest(input int t, input string name, input mipsPkg::word_t data,
                           input mipsPkg::word_t v0, input mipsPkg::word_t memWord);
        testName[t] = name;
        dataWord[t] = data;
        expectV0[t] = v0;
        expectMem[t] = memWord;
        programLength[t] = 0;
    endtask

    task automatic appendWord(input int t, input mipsPkg::word_t w);
        programWords[t][programLength[t]] = w;
        programLength[t] = programLength[t] + 1;
    endtask

    // JR $0 then a NOP in its slot
    task automatic appendHalt(input int t);
        appendWord(t, encodeR(0, 0, 0, 0, mipsPkg::FUNCT_JR));
        appendWord(t, encodeR(0, 0, 0, 0, mipsPkg::FUNCT_SLL));
    endtask

    task automatic buildTable();
        int addr;
        addr = int'(dataAddress);
        // Zero and sign extension both matter
        setTest(0, "immediate", 32'h11111111, 32'h12345668, 32'h000056F8);
        appendWord(0, encodeI(mipsPkg::OPCODE_LUI, 0, 8, 'h1234));
        appendWord(0, encodeI(mipsPkg::OPCODE_ORI, 8, 8, 'h5678));
        appendWord(0, encodeI(mipsPkg::OPCODE_ANDI, 8, 9, 'hFF0F));   // 0x5608
        appendWord(0, encodeI(mipsPkg::OPCODE_XORI, 9, 10, 'h80FF));  // 0xD6F7
        appendWord(0, encodeI(mipsPkg::OPCODE_ADDIU, 10, 11, 'h8001)); // 0x56F8
        appendWord(0, encodeI(mipsPkg::OPCODE_ADDIU, 8, 2, -16));
        appendWord(0, encodeI(mipsPkg::OPCODE_SW, 0, 11, addr));
        appendHalt(0);
        // Signed and unsigned compares of -16 against 5
        setTest(1, "register", 32'h0, 32'h5400000E, 32'h5400000E);
        appendWord(1, encodeI(mipsPkg::OPCODE_ADDIU, 0, 8, -16));
        appendWord(1, encodeI(mipsPkg::OPCODE_ADDIU, 0, 9, 5));
        appendWord(1, encodeR(8, 9, 10, 0, mipsPkg::FUNCT_SLT));   // 1
        appendWord(1, encodeR(8, 9, 11, 0, mipsPkg::FUNCT_SLTU));  // 0
        appendWord(1, encodeR(9, 8, 12, 0, mipsPkg::FUNCT_SUBU));  // 0x15
        appendWord(1, encodeR(0, 12, 13, 26, mipsPkg::FUNCT_SLL)); // 0x54000000
        appendWord(1, encodeR(0, 8, 14, 2, mipsPkg::FUNCT_SRA));   // 0xFFFFFFFC
        appendWord(1, encodeR(0, 8, 15, 28, mipsPkg::FUNCT_SRL));  // 0xF
        appendWord(1, encodeR(14, 13, 16, 0, mipsPkg::FUNCT_AND)); // Sign fill keeps bit 30
        appendWord(1, encodeR(16, 15, 17, 0, mipsPkg::FUNCT_OR));
        appendWord(1, encodeR(17, 10, 18, 0, mipsPkg::FUNCT_XOR));
        appendWord(1, encodeR(18, 11, 2, 0, mipsPkg::FUNCT_ADDU));
        appendWord(1, encodeI(mipsPkg::OPCODE_SW, 0, 2, addr));
        appendHalt(1);
        // Each ORI sets one bit and skipped words leave theirs clear
        setTest(2, "branch", 32'h0, 32'h0000006B, 32'h0000006B);
        appendWord(2, encodeI(mipsPkg::OPCODE_ADDIU, 0, 8, 7));
        appendWord(2, encodeBranch(mipsPkg::OPCODE_BEQ, 8, 0, 1, 4));  // Not taken
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h01));
        appendWord(2, encodeBranch(mipsPkg::OPCODE_BNE, 8, 0, 3, 6));  // Taken
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h02));       // Slot
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h04));       // Skipped
        appendWord(2, encodeBranch(mipsPkg::OPCODE_BEQ, 8, 8, 6, 9));  // Taken
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h08));
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h10));       // Skipped
        appendWord(2, encodeBranch(mipsPkg::OPCODE_BNE, 8, 8, 9, 12)); // Not taken
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h20));
        appendWord(2, encodeJump(14));
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h40));       // Jump slot
        appendWord(2, encodeI(mipsPkg::OPCODE_ORI, 2, 2, 'h80));       // Skipped
        appendWord(2, encodeI(mipsPkg::OPCODE_SW, 0, 2, addr));
        appendHalt(2);
        // Stored word replaces the preload through a negative offset
        setTest(3, "loadStore", 32'hCAFEF00D, 32'hDE568BEC, 32'h13579BDF);
        appendWord(3, encodeI(mipsPkg::OPCODE_LW, 0, 8, addr));
        appendWord(3, encodeI(mipsPkg::OPCODE_LUI, 0, 9, 'h1357));
        appendWord(3, encodeI(mipsPkg::OPCODE_ORI, 9, 9, 'h9BDF));
        appendWord(3, encodeI(mipsPkg::OPCODE_ADDIU, 0, 10, addr + 4));
        appendWord(3, encodeI(mipsPkg::OPCODE_SW, 10, 9, -4));
        appendWord(3, encodeI(mipsPkg::OPCODE_LW, 0, 2, addr));
        appendWord(3, encodeR(2, 8, 2, 0, mipsPkg::FUNCT_ADDU));
        appendHalt(3);
        // Writes to $0 are dropped
        setTest(4, "haltZero", 32'h87654321, 32'h00000055, 32'h0);
        appendWord(4, encodeI(mipsPkg::OPCODE_ADDIU, 0, 0, 'h1234));
        appendWord(4, encodeI(mipsPkg::OPCODE_ADDIU, 0, 2, 'h55));
        appendWord(4, encodeI(mipsPkg::OPCODE_LUI, 0, 0, 'hFFFF));
        appendWord(4, encodeR(2, 0, 2, 0, mipsPkg::FUNCT_OR));
        appendWord(4, encodeI(mipsPkg::OPCODE_SW, 0, 0, addr));
        appendHalt(4);
    endtask

    // Program, data word and fill through the preload port
    task automatic loadMemory(input int t);
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            #10;
            loadEnable = 1'b1;
            loadIndex = 6'(i);
            if (i < programLength[t]) begin
                loadData = programWords[t][i];
            end else if (6'(i) == peekIndex) begin
                loadData = dataWord[t];
            end else begin
                loadData = fillWord(i);
            end
        end
        @(posedge clk);
        #10;
        loadEnable = 1'b0;
    endtask

    task automatic applyReset();
        @(posedge clk);
        #10;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
    endtask

    initial begin
        int passCount;
        int failCount;
        int cycles;
        int holdBefore;
        logic testFailed;
        logic strayAccess;
        reset = 1'b1;
        loadEnable = 1'b0;
        loadIndex = '0;
        loadData = '0;
        dataAddress = 32'h00000080;
        passCount = 0;
        failCount = 0;
        buildTable();
        for (int t = 0; t < 5; t++) begin
            testFailed = 1'b0;
            strayAccess = 1'b0;
            loadMemory(t);
            applyReset();
            holdBefore = holdErrors;
            cycles = 0;
            while (active && cycles < 4000) begin  // Halt timeout
                @(negedge clk);
                cycles++;
            end
            if (active) begin
                $display("Test %s timed out, core still active after %0d cycles",
                         testName[t], cycles);
                testFailed = 1'b1;
            end else begin
                // Bus must stay quiet once halted
                for (int c = 0; c < 20; c++) begin
                    @(negedge clk);
                    if (active || read || write) begin
                        strayAccess = 1'b1;
                    end
                end
                if (strayAccess) begin
                    $display("Test %s saw bus activity or active high after halt", testName[t]);
                    testFailed = 1'b1;
                end
                if (holdErrors != holdBefore) begin
                    $display("Test %s changed a bus request while waitrequest was high",
                             testName[t]);
                    testFailed = 1'b1;
                end
                if (register_v0 !== expectV0[t]) begin
                    $display("MISMATCH %s register_v0 expected %h actual %h",
                             testName[t], expectV0[t], register_v0);
                    testFailed = 1'b1;
                end
                if (peekData !== expectMem[t]) begin
                    $display("MISMATCH %s memory word expected %h actual %h",
                             testName[t], expectMem[t], peekData);
                    testFailed = 1'b1;
                end
                if (byteenable !== 4'hF) begin
                    $display("MISMATCH %s byteenable expected %h actual %h",
                             testName[t], 4'hF, byteenable);
                    testFailed = 1'b1;
                end
            end
            if (testFailed) begin
                failCount++;
                $display("Test %s failed after %0d cycles", testName[t], cycles);
            end else begin
                passCount++;
                $display("Test %s passed in %0d cycles", testName[t], cycles);
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d", passCount + failCount,
                 passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/mipsPkg.sv
design/busMaster.sv
design/cpuControl.sv
design/aluUnit.sv
design/registerFile.sv
design/mipsCpuBus.sv
sim/avalonMemory.sv
sim/mipsCpuBusTb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module mipsCpuBusTb -f filelist.f -o mipsCpuBusTb \
    && ./obj_dir/mipsCpuBusTb > sim.log 2>&1
grep -qsx "TEST PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
